// ==== common/periph_params.svh ====
// ----------------------------------------
// Address map, GPIO width and interrupt
// counts for the peripheral subsystem
// ----------------------------------------

`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Subsystem window, upper 20 bits must match the base
`define PERIPH_BASE     32'h2000_0000
`define PERIPH_WIN_BITS 12

// 4-bit select field, 0 GPIO, 1 timer, 2 PLIC
`define PERIPH_SEL_LSB  8

`define GPIO_WIDTH      8
`define NUM_EXT_IRQ     4

// ID 0 reserved, 1 timer, 2..9 GPIO, 10..13 external
`define NUM_IRQ_SRC     14

`endif

// ==== common/periph_pkg.sv ====
// ----------------------------------------
// Vector types shared by the subsystem RTL
// and its testbench
// ----------------------------------------

`include "periph_params.svh"

package periph_pkg;

  // Bus data and address
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Register offset inside one peripheral
  typedef logic [7:0] reg_off_t;

  // GPIO pin vector
  typedef logic [`GPIO_WIDTH-1:0] gpio_t;

  // PLIC source vector and source ID
  typedef logic [`NUM_IRQ_SRC-1:0] irq_src_t;
  typedef logic [3:0] irq_id_t;

endpackage : periph_pkg

// ==== src/obi_to_reg.sv ====
// ----------------------------------------
// Bus to register-strobe bridge, grants
// every request, response one cycle later
// ----------------------------------------

`timescale 1ns/100ps

module obi_to_reg
  import periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,

  input  logic  req_i,
  input  addr_t addr_i,
  input  logic  we_i,
  input  word_t wdata_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output word_t rdata_o,
  output logic  err_o,

  output logic  reg_valid_o,
  output logic  reg_we_o,
  output addr_t reg_addr_o,
  output word_t reg_wdata_o,
  input  word_t reg_rdata_i,
  input  logic  reg_err_i
);

  logic  rvalid_q;
  logic  err_q;
  word_t rdata_q;

  // No slave can stall
  assign gnt_o = req_i;

  // One strobe per granted transfer
  assign reg_valid_o = req_i & gnt_o;
  assign reg_we_o    = we_i;
  assign reg_addr_o  = addr_i;
  assign reg_wdata_o = wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= reg_valid_o;
      err_q    <= reg_valid_o & reg_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_valid_o) begin
      rdata_q <= reg_rdata_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;
  assign rdata_o  = rdata_q;

endmodule : obi_to_reg

// ==== src/periph_reg_decode.sv ====
// ----------------------------------------
// Combinational address decoder, routes a
// register strobe to one peripheral
// ----------------------------------------

`timescale 1ns/100ps

`include "periph_params.svh"

module periph_reg_decode
  import periph_pkg::*;
(
  input  logic     reg_valid_i,
  input  logic     reg_we_i,
  input  addr_t    reg_addr_i,
  input  word_t    reg_wdata_i,
  output word_t    reg_rdata_o,
  output logic     reg_err_o,

  output logic     gpio_valid_o,
  output logic     gpio_we_o,
  output reg_off_t gpio_off_o,
  output word_t    gpio_wdata_o,
  input  word_t    gpio_rdata_i,

  output logic     tmr_valid_o,
  output logic     tmr_we_o,
  output reg_off_t tmr_off_o,
  output word_t    tmr_wdata_o,
  input  word_t    tmr_rdata_i,

  output logic     plic_valid_o,
  output logic     plic_we_o,
  output reg_off_t plic_off_o,
  output word_t    plic_wdata_o,
  input  word_t    plic_rdata_i
);

  localparam addr_t BASE_ADDR = `PERIPH_BASE;

  logic       in_win;
  logic [3:0] sel;
  logic       hit_gpio;
  logic       hit_tmr;
  logic       hit_plic;
  reg_off_t   off;

  assign in_win = reg_addr_i[31:`PERIPH_WIN_BITS] == BASE_ADDR[31:`PERIPH_WIN_BITS];
  assign sel    = reg_addr_i[`PERIPH_SEL_LSB +: 4];
  assign off    = reg_addr_i[`PERIPH_SEL_LSB-1:0];

  assign hit_gpio = in_win && (sel == 4'd0);
  assign hit_tmr  = in_win && (sel == 4'd1);
  assign hit_plic = in_win && (sel == 4'd2);

  // Only the selected peripheral gets a valid
  assign gpio_valid_o = reg_valid_i & hit_gpio;
  assign tmr_valid_o  = reg_valid_i & hit_tmr;
  assign plic_valid_o = reg_valid_i & hit_plic;

  assign gpio_we_o    = reg_we_i;
  assign gpio_off_o   = off;
  assign gpio_wdata_o = reg_wdata_i;
  assign tmr_we_o     = reg_we_i;
  assign tmr_off_o    = off;
  assign tmr_wdata_o  = reg_wdata_i;
  assign plic_we_o    = reg_we_i;
  assign plic_off_o   = off;
  assign plic_wdata_o = reg_wdata_i;

  always_comb begin
    if (hit_gpio) begin
      reg_rdata_o = gpio_rdata_i;
    end else if (hit_tmr) begin
      reg_rdata_o = tmr_rdata_i;
    end else if (hit_plic) begin
      reg_rdata_o = plic_rdata_i;
    end else begin
      reg_rdata_o = '0;
    end
  end

  assign reg_err_o = reg_valid_i & ~(hit_gpio | hit_tmr | hit_plic);

endmodule : periph_reg_decode

// ==== gpio/periph_gpio.sv ====
// ----------------------------------------
// GPIO with output enables and rising-edge
// interrupts on synchronised inputs
// ----------------------------------------

`timescale 1ns/100ps

module periph_gpio
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  logic     we_i,
  input  reg_off_t off_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  input  gpio_t    gpio_i,
  output gpio_t    gpio_o,
  output gpio_t    gpio_en_o,
  output gpio_t    intr_o
);

  gpio_t sync_q1;
  gpio_t sync_q2;
  gpio_t prev_q;
  gpio_t data_out;
  gpio_t out_en;
  gpio_t intr_en;
  gpio_t intr_state;
  gpio_t rise;
  logic  wr;

  assign wr   = valid_i & we_i;
  assign rise = sync_q2 & ~prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1    <= '0;
      sync_q2    <= '0;
      prev_q     <= '0;
      data_out   <= '0;
      out_en     <= '0;
      intr_en    <= '0;
      intr_state <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      if (wr && off_i == 8'h04) data_out <= gpio_t'(wdata_i);
      if (wr && off_i == 8'h08) out_en <= gpio_t'(wdata_i);
      if (wr && off_i == 8'h0C) intr_en <= gpio_t'(wdata_i);
      // New edges win over a write-1-to-clear
      if (wr && off_i == 8'h10) begin
        intr_state <= (intr_state & ~gpio_t'(wdata_i)) | rise;
      end else begin
        intr_state <= intr_state | rise;
      end
    end
  end

  always_comb begin
    case (off_i)
      8'h00:   rdata_o = word_t'(sync_q2);
      8'h04:   rdata_o = word_t'(data_out);
      8'h08:   rdata_o = word_t'(out_en);
      8'h0C:   rdata_o = word_t'(intr_en);
      8'h10:   rdata_o = word_t'(intr_state);
      default: rdata_o = '0;
    endcase
  end

  assign gpio_o    = data_out;
  assign gpio_en_o = out_en;
  assign intr_o    = intr_state & intr_en;

endmodule : periph_gpio

// ==== timer/periph_timer.sv ====
// ----------------------------------------
// Free-running 32-bit timer with compare
// interrupt, MTIME is writable
// ----------------------------------------

`timescale 1ns/100ps

module periph_timer
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  logic     we_i,
  input  reg_off_t off_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  output logic     intr_o
);

  word_t      mtime;
  word_t      cmp;
  logic [1:0] ctrl;
  logic       wr;

  assign wr = valid_i & we_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime <= '0;
      cmp   <= '0;
      ctrl  <= '0;
    end else begin
      // Software load overrides the increment
      if (wr && off_i == 8'h00) begin
        mtime <= wdata_i;
      end else if (ctrl[0]) begin
        mtime <= mtime + 32'd1;
      end
      if (wr && off_i == 8'h04) ctrl <= wdata_i[1:0];
      if (wr && off_i == 8'h08) cmp <= wdata_i;
    end
  end

  always_comb begin
    case (off_i)
      8'h00:   rdata_o = mtime;
      8'h04:   rdata_o = {30'b0, ctrl};
      8'h08:   rdata_o = cmp;
      default: rdata_o = '0;
    endcase
  end

  assign intr_o = ctrl[1] && (mtime >= cmp);

endmodule : periph_timer

// ==== plic/periph_plic.sv ====
// ----------------------------------------
// Interrupt controller, lowest pending ID
// wins, claim on read, complete on write
// ----------------------------------------

`timescale 1ns/100ps

`include "periph_params.svh"

module periph_plic
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  logic     we_i,
  input  reg_off_t off_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  input  irq_src_t src_i,
  output logic     irq_o,
  output logic     msip_o
);

  irq_src_t enable;
  irq_src_t pending;
  irq_src_t in_service;
  irq_src_t claim_mask;
  irq_src_t done_mask;
  irq_src_t src_set;
  irq_id_t  claim_id;
  logic     msip;
  logic     claim_rd;
  logic     complete_wr;

  // Lowest enabled pending ID, 0 when idle
  always_comb begin
    claim_id = '0;
    for (int i = `NUM_IRQ_SRC - 1; i > 0; i--) begin
      if (pending[i] && enable[i]) claim_id = irq_id_t'(i);
    end
  end

  assign claim_rd    = valid_i && !we_i && off_i == 8'h08;
  assign complete_wr = valid_i && we_i && off_i == 8'h08;

  assign claim_mask = (claim_rd && claim_id != '0) ? irq_src_t'(1) << claim_id : '0;
  assign done_mask  = complete_wr ? irq_src_t'(1) << irq_id_t'(wdata_i) : '0;

  // Source 0 never pends
  assign src_set = src_i & ~in_service & ~irq_src_t'(1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable     <= '0;
      pending    <= '0;
      in_service <= '0;
      msip       <= 1'b0;
    end else begin
      pending    <= (pending | src_set) & ~claim_mask;
      in_service <= (in_service | claim_mask) & ~done_mask;
      if (valid_i && we_i && off_i == 8'h00) enable <= irq_src_t'(wdata_i);
      if (valid_i && we_i && off_i == 8'h0C) msip <= wdata_i[0];
    end
  end

  always_comb begin
    case (off_i)
      8'h00:   rdata_o = word_t'(enable);
      8'h04:   rdata_o = word_t'(pending);
      8'h08:   rdata_o = word_t'(claim_id);
      8'h0C:   rdata_o = {31'b0, msip};
      default: rdata_o = '0;
    endcase
  end

  assign irq_o  = |(pending & enable);
  assign msip_o = msip;

endmodule : periph_plic

// ==== src/peripheral_subsystem.sv ====
// ----------------------------------------
// Subsystem top: bus bridge, decoder and
// the GPIO, timer and PLIC peripherals
// ----------------------------------------

`timescale 1ns/100ps

`include "periph_params.svh"

module peripheral_subsystem
  import periph_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,

  input  logic                    req_i,
  input  addr_t                   addr_i,
  input  logic                    we_i,
  input  word_t                   wdata_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output word_t                   rdata_o,
  output logic                    err_o,

  input  gpio_t                   gpio_i,
  output gpio_t                   gpio_o,
  output gpio_t                   gpio_en_o,
  output gpio_t                   gpio_intr_o,
  output logic                    timer_intr_o,

  input  logic [`NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                    irq_o,
  output logic                    msip_o
);

  logic     reg_valid, reg_we, reg_err;
  addr_t    reg_addr;
  word_t    reg_wdata, reg_rdata;

  logic     gpio_valid, gpio_we, tmr_valid, tmr_we, plic_valid, plic_we;
  reg_off_t gpio_off, tmr_off, plic_off;
  word_t    gpio_wdata, gpio_rdata, tmr_wdata, tmr_rdata, plic_wdata, plic_rdata;
  irq_src_t irq_src;

  // ID 0 tied low, then timer, GPIO pins, external lines
  assign irq_src = {ext_irq_i, gpio_intr_o, timer_intr_o, 1'b0};

  obi_to_reg i_obi_to_reg (
    .clk_i, .arst_n_i,
    .req_i, .addr_i, .we_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o, .err_o,
    .reg_valid_o(reg_valid), .reg_we_o(reg_we), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata), .reg_err_i(reg_err)
  );

  periph_reg_decode i_reg_decode (
    .reg_valid_i(reg_valid), .reg_we_i(reg_we), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata), .reg_err_o(reg_err),
    .gpio_valid_o(gpio_valid), .gpio_we_o(gpio_we), .gpio_off_o(gpio_off),
    .gpio_wdata_o(gpio_wdata), .gpio_rdata_i(gpio_rdata),
    .tmr_valid_o(tmr_valid), .tmr_we_o(tmr_we), .tmr_off_o(tmr_off),
    .tmr_wdata_o(tmr_wdata), .tmr_rdata_i(tmr_rdata),
    .plic_valid_o(plic_valid), .plic_we_o(plic_we), .plic_off_o(plic_off),
    .plic_wdata_o(plic_wdata), .plic_rdata_i(plic_rdata)
  );

  periph_gpio i_gpio (
    .clk_i, .arst_n_i,
    .valid_i(gpio_valid), .we_i(gpio_we), .off_i(gpio_off),
    .wdata_i(gpio_wdata), .rdata_o(gpio_rdata),
    .gpio_i, .gpio_o, .gpio_en_o, .intr_o(gpio_intr_o)
  );

  periph_timer i_timer (
    .clk_i, .arst_n_i,
    .valid_i(tmr_valid), .we_i(tmr_we), .off_i(tmr_off),
    .wdata_i(tmr_wdata), .rdata_o(tmr_rdata), .intr_o(timer_intr_o)
  );

  periph_plic i_plic (
    .clk_i, .arst_n_i,
    .valid_i(plic_valid), .we_i(plic_we), .off_i(plic_off),
    .wdata_i(plic_wdata), .rdata_o(plic_rdata),
    .src_i(irq_src), .irq_o, .msip_o
  );

endmodule : peripheral_subsystem

// ==== verification/peripheral_subsystem_chk.sv ====
// ----------------------------------------
// Bus handshake and interrupt assertions,
// bound into the subsystem top
// ----------------------------------------

`timescale 1ns/100ps

module peripheral_subsystem_chk
  import periph_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input logic     req_i,
  input logic     gnt_i,
  input logic     rvalid_i,
  input logic     err_i,
  input logic     irq_i,
  input irq_src_t plic_en_i
);

  int fail_cnt = 0;

  grant_then_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_i |=> rvalid_i)
    else begin
      $error("rvalid_o missing one cycle after a grant");
      fail_cnt++;
    end

  rvalid_needs_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i |-> $past(gnt_i))
    else begin
      $error("rvalid_o without a grant in the previous cycle");
      fail_cnt++;
    end

  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_i |-> rvalid_i)
    else begin
      $error("err_o high without rvalid_o");
      fail_cnt++;
    end

  gnt_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_i == req_i)
    else begin
      $error("gnt_o differs from req_i");
      fail_cnt++;
    end

  // Nothing enabled means no interrupt
  irq_needs_enable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (plic_en_i == '0) |-> !irq_i)
    else begin
      $error("irq_o high with no source enabled");
      fail_cnt++;
    end

endmodule : peripheral_subsystem_chk

bind peripheral_subsystem peripheral_subsystem_chk u_chk (
  .clk_i,
  .arst_n_i,
  .req_i,
  .gnt_i(gnt_o),
  .rvalid_i(rvalid_o),
  .err_i(err_o),
  .irq_i(irq_o),
  .plic_en_i(i_plic.enable)
);

// ==== verification/peripheral_subsystem_tb.sv ====
// ----------------------------------------
// Directed testbench for the peripheral
// subsystem through its bus port
// ----------------------------------------

`timescale 1ns/100ps

`include "periph_params.svh"

module peripheral_subsystem_tb
  import periph_pkg::*;
();

  localparam addr_t GPIO_BASE  = `PERIPH_BASE;
  localparam addr_t TMR_BASE   = `PERIPH_BASE + (32'd1 << `PERIPH_SEL_LSB);
  localparam addr_t PLIC_BASE  = `PERIPH_BASE + (32'd2 << `PERIPH_SEL_LSB);
  localparam int    WAIT_LIMIT = 200;
  localparam int    BURST_LEN  = 30;
  localparam int    SEED       = 23377;
  localparam int    EV_GPIO3   = 0;
  localparam int    EV_TIMER   = 1;
  localparam int    EV_IRQ     = 2;

  logic                    clk;
  logic                    arst_n;
  logic                    req;
  addr_t                   addr;
  logic                    we;
  word_t                   wdata;
  logic                    gnt;
  logic                    rvalid;
  word_t                   rdata;
  logic                    err;
  gpio_t                   gpio_in;
  gpio_t                   gpio_out;
  gpio_t                   gpio_en;
  gpio_t                   gpio_intr;
  logic                    timer_intr;
  logic [`NUM_EXT_IRQ-1:0] ext_irq;
  logic                    irq;
  logic                    msip;

  int    errors;
  int    timeouts;
  int    tests_run;
  int    tests_bad;
  int    mark;
  word_t rd;
  logic  rd_err;

  peripheral_subsystem dut (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .req_i(req),
    .addr_i(addr),
    .we_i(we),
    .wdata_i(wdata),
    .gnt_o(gnt),
    .rvalid_o(rvalid),
    .rdata_o(rdata),
    .err_o(err),
    .gpio_i(gpio_in),
    .gpio_o(gpio_out),
    .gpio_en_o(gpio_en),
    .gpio_intr_o(gpio_intr),
    .timer_intr_o(timer_intr),
    .ext_irq_i(ext_irq),
    .irq_o(irq),
    .msip_o(msip)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic expect_eq(input word_t got, input word_t exp, input string what);
    assert (got === exp) else begin
      $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("FAIL %0t: %s", $time, what);
      errors++;
    end
  endtask

  // One transfer entered and left on a falling edge
  task automatic bus_access(input addr_t a, input logic w, input word_t d,
                            output word_t q, output logic e);
    int waited;
    req    = 1'b1;
    addr   = a;
    we     = w;
    wdata  = d;
    @(negedge clk);
    req    = 1'b0;
    waited = 0;
    while (rvalid !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rvalid !== 1'b1) begin
      $display("Timeout: no bus response for address %h", a);
      timeouts++;
    end
    q = rdata;
    e = err;
  endtask

  task automatic write_reg(input addr_t a, input word_t d);
    word_t q;
    logic  e;
    bus_access(a, 1'b1, d, q, e);
    expect_true(!e, $sformatf("write to %h without error", a));
  endtask

  task automatic read_reg(input addr_t a, output word_t q);
    logic e;
    bus_access(a, 1'b0, '0, q, e);
    expect_true(!e, $sformatf("read from %h without error", a));
  endtask

  function automatic logic event_seen(input int kind);
    case (kind)
      EV_GPIO3: return gpio_intr[3];
      EV_TIMER: return timer_intr;
      default:  return irq;
    endcase
  endfunction

  task automatic await_event(input int kind, input string what);
    int waited;
    waited = 0;
    while (event_seen(kind) !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (event_seen(kind) !== 1'b1) begin
      $display("Timeout: %s never went high", what);
      timeouts++;
    end
  endtask

  // Claim and complete whatever earlier tests left pending
  task automatic drain_plic();
    word_t id;
    write_reg(PLIC_BASE, word_t'((1 << `NUM_IRQ_SRC) - 2));
    for (int n = 0; n < `NUM_IRQ_SRC; n++) begin
      read_reg(PLIC_BASE + 32'h08, id);
      if (id != '0) write_reg(PLIC_BASE + 32'h08, id);
    end
    write_reg(PLIC_BASE, 32'h0);
  endtask

  // Alternate DATA_OUT writes and reads with two transfers in flight
  task automatic burst_traffic();
    word_t last_wr;
    logic  was_read;
    last_wr  = '0;
    was_read = 1'b0;
    for (int cyc = 0; cyc <= BURST_LEN; cyc++) begin
      if (cyc > 0) begin
        expect_true(rvalid === 1'b1 && err === 1'b0, "burst response one cycle after grant");
        if (was_read) expect_eq(rdata, last_wr, "burst readback of DATA_OUT");
      end
      if (cyc < BURST_LEN) begin
        was_read = cyc[0];
        req      = 1'b1;
        addr     = GPIO_BASE + 32'h04;
        we       = ~cyc[0];
        if (!cyc[0]) begin
          wdata   = $urandom;
          last_wr = word_t'(gpio_t'(wdata));
        end
      end else begin
        req = 1'b0;
      end
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors + timeouts == mark) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("Test %0d %s: %0d problems", tests_run, name, errors + timeouts - mark);
    end
    mark = errors + timeouts;
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n    = 1'b0;
    req       = 1'b0;
    addr      = '0;
    we        = 1'b0;
    wdata     = '0;
    gpio_in   = '0;
    ext_irq   = '0;
    errors    = 0;
    timeouts  = 0;
    tests_run = 0;
    tests_bad = 0;
    mark      = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    write_reg(GPIO_BASE + 32'h04, 32'hA5);
    write_reg(GPIO_BASE + 32'h08, 32'h0F);
    expect_eq(word_t'(gpio_out), 32'hA5, "gpio_o after DATA_OUT write");
    expect_eq(word_t'(gpio_en), 32'h0F, "gpio_en_o after OUT_EN write");
    read_reg(GPIO_BASE + 32'h04, rd);
    expect_eq(rd, 32'hA5, "DATA_OUT readback");
    read_reg(GPIO_BASE + 32'h08, rd);
    expect_eq(rd, 32'h0F, "OUT_EN readback");
    report_test("gpio output");

    write_reg(GPIO_BASE + 32'h0C, 32'h08);
    gpio_in[3] = 1'b1;
    await_event(EV_GPIO3, "gpio_intr_o bit 3");
    read_reg(GPIO_BASE + 32'h10, rd);
    expect_eq(rd, 32'h08, "INTR_STATE after rising edge");
    read_reg(GPIO_BASE + 32'h00, rd);
    expect_eq(rd, 32'h08, "DATA_IN with pin 3 high");
    write_reg(GPIO_BASE + 32'h10, 32'h08);
    read_reg(GPIO_BASE + 32'h10, rd);
    expect_eq(rd, 32'h0, "INTR_STATE after write-1 clear");
    expect_true(gpio_intr[3] === 1'b0, "gpio_intr_o bit 3 low after clear");
    gpio_in[3] = 1'b0;
    write_reg(GPIO_BASE + 32'h0C, 32'h0);
    report_test("gpio interrupt");

    write_reg(TMR_BASE + 32'h08, 32'd20);
    write_reg(TMR_BASE + 32'h00, 32'd0);
    write_reg(TMR_BASE + 32'h04, 32'h3);
    await_event(EV_TIMER, "timer_intr_o");
    read_reg(TMR_BASE + 32'h00, rd);
    expect_true(rd >= 32'd20, "MTIME at least CMP once the interrupt fires");
    write_reg(TMR_BASE + 32'h04, 32'h0);
    expect_true(timer_intr === 1'b0, "timer_intr_o low once disabled");
    report_test("timer compare");

    drain_plic();
    // External line n is PLIC ID 10 + n
    write_reg(PLIC_BASE, (32'd1 << 1) | (32'd1 << 10) | (32'd1 << 12));
    ext_irq[0] = 1'b1;
    ext_irq[2] = 1'b1;
    await_event(EV_IRQ, "irq_o");
    read_reg(PLIC_BASE + 32'h08, rd);
    expect_eq(rd, 32'd10, "first claim");
    ext_irq[0] = 1'b0;
    write_reg(PLIC_BASE + 32'h08, 32'd10);
    read_reg(PLIC_BASE + 32'h08, rd);
    expect_eq(rd, 32'd12, "second claim");
    ext_irq[2] = 1'b0;
    write_reg(PLIC_BASE + 32'h08, 32'd12);
    expect_true(irq === 1'b0, "irq_o low after both completes");
    write_reg(PLIC_BASE + 32'h0C, 32'h1);
    expect_true(msip === 1'b1, "msip_o set by MSIP write");
    write_reg(PLIC_BASE + 32'h0C, 32'h0);
    expect_true(msip === 1'b0, "msip_o cleared by MSIP write");
    write_reg(PLIC_BASE, 32'h0);
    report_test("plic claim and complete");

    bus_access(`PERIPH_BASE + (32'd5 << `PERIPH_SEL_LSB), 1'b0, '0, rd, rd_err);
    expect_true(rd_err === 1'b1, "err_o on select 5");
    expect_eq(rd, 32'h0, "read data on select 5");
    bus_access(32'h3000_0000, 1'b0, '0, rd, rd_err);
    expect_true(rd_err === 1'b1, "err_o outside the base window");
    expect_eq(rd, 32'h0, "read data outside the base window");
    read_reg(GPIO_BASE + 32'h04, rd);
    expect_eq(rd, 32'hA5, "GPIO readback after unmapped accesses");
    report_test("unmapped access");

    burst_traffic();
    report_test("back-to-back traffic");

    $display("Tests %0d, with problems %0d, errors %0d, timeouts %0d, assertion failures %0d",
             tests_run, tests_bad, errors, timeouts, dut.u_chk.fail_cnt);
    if (errors == 0 && timeouts == 0 && dut.u_chk.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : peripheral_subsystem_tb

// ==== vlog.f ====
+incdir+common
common/periph_pkg.sv
src/obi_to_reg.sv
src/periph_reg_decode.sv
gpio/periph_gpio.sv
timer/periph_timer.sv
plic/periph_plic.sv
src/peripheral_subsystem.sv
verification/peripheral_subsystem_chk.sv
verification/peripheral_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f vlog.f \
  --top-module peripheral_subsystem_tb -Mdir obj_dir -o sim_tb > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"

if grep -q "Simulation failed" "$sim_log"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation run exited with status $run_status"
  exit 1
fi
if ! grep -q "Simulation passed" "$sim_log"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
